/* Makefile */
SRCS := $(shell cat compile.f)

obj_dir/Vtb_synth_engine: compile.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_synth_engine -f compile.f

.PHONY: run clean

run: obj_dir/Vtb_synth_engine
	@out="$$(./obj_dir/Vtb_synth_engine 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* compile.f */
synth_pkg.sv
synth_if.sv
synth_clk_gen.sv
note_key_vel_sync.sv
pitch_control.sv
osc.sv
env_gen_indexed.sv
mixer.sv
synth_engine.sv
tb_synth_engine.sv

/* env_gen_indexed.sv */
`timescale 1ns/1ps
`default_nettype none

module env_gen_indexed #(
    parameter int VOICES = synth_pkg::VOICES
) (
    input  wire                 audio_clk,
    input  wire                 reset,
    slot_if.monitor             slot,
    cfg_if.env_cfg              cfg,
    input  wire [VOICES-1:0]    reg_keys_on,
    output synth_pkg::level_t   level_mul,
    output logic [VOICES-1:0]   voice_free
);

    synth_pkg::level_t level [VOICES];
    synth_pkg::level_t attack_rate;
    synth_pkg::level_t release_rate;
    synth_pkg::voice_t voice_d1;
    synth_pkg::level_t cur;
    synth_pkg::level_t lvl_nxt;
    logic [8:0]        rise;

    always_comb begin
        cur  = level[slot.voice];
        rise = {1'b0, cur} + {1'b0, attack_rate};
        if (reg_keys_on[slot.voice]) begin
            lvl_nxt = rise[8] ? 8'hff : rise[7:0];            // saturate at full scale
        end else begin
            lvl_nxt = (cur > release_rate) ? cur - release_rate : '0;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (reset) begin
            attack_rate  <= '0;
            release_rate <= '0;
        end else if (cfg.write && cfg.env_sel) begin
            if (cfg.adr == synth_pkg::ADR_ATTACK)  attack_rate  <= cfg.data;
            if (cfg.adr == synth_pkg::ADR_RELEASE) release_rate <= cfg.data;
        end
    end

    // one step per voice per frame, on its oscillator-0 slot
    always_ff @(posedge audio_clk) begin
        if (reset) begin
            for (int v = 0; v < VOICES; v++) begin
                level[v] <= '0;
            end
        end else if (slot.slot_valid && slot.osc == '0) begin
            level[slot.voice] <= lvl_nxt;
        end
    end

    // extra stage lines the level up with the osc sample
    always_ff @(posedge audio_clk) begin
        voice_d1  <= slot.voice;
        level_mul <= level[voice_d1];
    end

    always_comb begin
        for (int v = 0; v < VOICES; v++) begin
            voice_free[v] = (level[v] == '0) && !reg_keys_on[v];
        end
    end

endmodule

`default_nettype wire

/* mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module mixer #(
    parameter int VOICES = synth_pkg::VOICES
) (
    input  wire                     audio_clk,
    input  wire                     reset,
    slot_if.monitor                 slot_d2,
    input  wire synth_pkg::sample_t sample,
    input  wire                     pan,
    input  wire synth_pkg::level_t  level_mul,
    input  wire synth_pkg::vel_t    voice_vel [VOICES],
    output synth_pkg::sample_t      lsound_out,
    output synth_pkg::sample_t      rsound_out,
    output logic                    sample_valid
);

    logic signed [33:0] prod_full;
    synth_pkg::acc_t    prod;
    synth_pkg::acc_t    acc_l;
    synth_pkg::acc_t    acc_r;
    synth_pkg::acc_t    sum_l;
    synth_pkg::acc_t    sum_r;

    function automatic synth_pkg::sample_t sat16(synth_pkg::acc_t a);
        if (a > 24'sd32767)  return 16'sd32767;
        if (a < -24'sd32768) return -16'sd32768;
        return synth_pkg::sample_t'(a);
    endfunction

    always_comb begin
        prod_full = sample * $signed({1'b0, level_mul})
                  * $signed({1'b0, voice_vel[slot_d2.voice]});
        prod      = synth_pkg::acc_t'(prod_full >>> 16);
        // first slot of a frame starts a fresh sum
        sum_l     = (slot_d2.frame_start ? synth_pkg::acc_t'(0) : acc_l)
                  + (pan ? synth_pkg::acc_t'(0) : prod);
        sum_r     = (slot_d2.frame_start ? synth_pkg::acc_t'(0) : acc_r)
                  + (pan ? prod : synth_pkg::acc_t'(0));
    end

    always_ff @(posedge audio_clk) begin
        if (reset) begin
            acc_l        <= '0;
            acc_r        <= '0;
            lsound_out   <= '0;
            rsound_out   <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (slot_d2.slot_valid) begin
                acc_l <= sum_l;
                acc_r <= sum_r;
                if (slot_d2.frame_end) begin        // last slot closes the frame
                    lsound_out   <= sat16(sum_l);
                    rsound_out   <= sat16(sum_r);
                    sample_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* note_key_vel_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module note_key_vel_sync #(
    parameter int VOICES = synth_pkg::VOICES
) (
    input  wire                     audio_clk,
    input  wire                     reset,
    input  wire                     frame_start,
    input  wire                     note_on,
    input  wire synth_pkg::voice_t  cur_key_adr,
    input  wire synth_pkg::key_t    cur_key_val,
    input  wire synth_pkg::vel_t    cur_vel_on,
    input  wire [VOICES-1:0]        keys_on,
    output synth_pkg::key_t         voice_key [VOICES],
    output synth_pkg::vel_t         voice_vel [VOICES],
    output logic [VOICES-1:0]       reg_keys_on
);

    synth_pkg::key_t   key_r [VOICES];
    synth_pkg::vel_t   vel_r [VOICES];
    logic [VOICES-1:0] keys_r;

    always_ff @(posedge audio_clk) begin
        if (reset) begin
            keys_r <= '0;
            for (int v = 0; v < VOICES; v++) begin
                key_r[v] <= '0;
                vel_r[v] <= '0;
            end
        end else if (frame_start) begin
            keys_r <= keys_on;
            if (note_on) begin
                key_r[cur_key_adr] <= cur_key_val;
                vel_r[cur_key_adr] <= cur_vel_on;
            end
        end
    end

    // slot 0 already needs this frame's notes, so pass them through on frame start
    always_comb begin
        reg_keys_on = frame_start ? keys_on : keys_r;
        for (int v = 0; v < VOICES; v++) begin
            voice_key[v] = key_r[v];
            voice_vel[v] = vel_r[v];
        end
        if (frame_start && note_on) begin
            voice_key[cur_key_adr] = cur_key_val;
            voice_vel[cur_key_adr] = cur_vel_on;
        end
    end

endmodule

`default_nettype wire

/* osc.sv */
`timescale 1ns/1ps
`default_nettype none

module osc #(
    parameter int VOICES = synth_pkg::VOICES,
    parameter int V_OSC  = synth_pkg::V_OSC
) (
    input  wire                     audio_clk,
    input  wire                     reset,
    slot_if.monitor                 slot_d1,
    cfg_if.osc_cfg                  cfg,
    input  wire synth_pkg::phase_t  osc_inc,
    output synth_pkg::sample_t      sample,
    output logic                    pan,
    slot_if.source                  slot_d2     // slot fields aligned with sample
);

    localparam int SLOTS = VOICES * V_OSC;

    synth_pkg::phase_t phase   [SLOTS];
    synth_pkg::wave_e  wave    [SLOTS];
    logic              pan_reg [SLOTS];
    int                slot_idx;
    int                wave_idx;
    int                pan_idx;
    synth_pkg::phase_t phase_nxt;

    function automatic synth_pkg::sample_t shape(synth_pkg::wave_e w, synth_pkg::phase_t p);
        synth_pkg::phase_t tri_w;
        tri_w = p[15] ? ~{p[14:0], 1'b0} : {p[14:0], 1'b0};
        case (w)
            synth_pkg::wave_square: return p[15] ? -16'sd16384 : 16'sd16383;
            synth_pkg::wave_tri:    return synth_pkg::sample_t'(tri_w - 16'h8000);
            default:                return synth_pkg::sample_t'(p);     // saw
        endcase
    endfunction

    always_comb begin
        slot_idx  = int'(slot_d1.voice) * V_OSC + int'(slot_d1.osc);
        wave_idx  = int'(cfg.adr) - int'(synth_pkg::ADR_WAVE);
        pan_idx   = int'(cfg.adr) - int'(synth_pkg::ADR_PAN);
        phase_nxt = phase[slot_idx] + osc_inc;
    end

    always_ff @(posedge audio_clk) begin
        if (reset) begin
            for (int i = 0; i < SLOTS; i++) begin
                wave[i]    <= synth_pkg::wave_saw;
                pan_reg[i] <= 1'b0;
            end
        end else if (cfg.write && cfg.osc_sel) begin
            if (wave_idx >= 0 && wave_idx < SLOTS) wave[wave_idx] <= synth_pkg::wave_e'(cfg.data[1:0]);
            if (pan_idx >= 0 && pan_idx < SLOTS)   pan_reg[pan_idx] <= cfg.data[0];
        end
    end

    always_ff @(posedge audio_clk) begin
        if (reset) begin
            for (int i = 0; i < SLOTS; i++) begin
                phase[i] <= '0;
            end
        end else if (slot_d1.slot_valid) begin
            phase[slot_idx] <= phase_nxt;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (reset) begin
            slot_d2.slot_valid  <= 1'b0;
            slot_d2.frame_start <= 1'b0;
            slot_d2.frame_end   <= 1'b0;
        end else begin
            slot_d2.slot_valid  <= slot_d1.slot_valid;
            slot_d2.frame_start <= slot_d1.frame_start;
            slot_d2.frame_end   <= slot_d1.frame_end;
        end
    end

    always_ff @(posedge audio_clk) begin
        sample        <= shape(wave[slot_idx], phase_nxt);   // shape the advanced phase
        pan           <= pan_reg[slot_idx];
        slot_d2.voice <= slot_d1.voice;
        slot_d2.osc   <= slot_d1.osc;
    end

endmodule

`default_nettype wire

/* pitch_control.sv */
`timescale 1ns/1ps
`default_nettype none

module pitch_control #(
    parameter int VOICES = synth_pkg::VOICES,
    parameter int V_OSC  = synth_pkg::V_OSC
) (
    input  wire                     audio_clk,
    input  wire                     reset,
    slot_if.monitor                 slot,
    cfg_if.osc_cfg                  cfg,
    input  wire synth_pkg::key_t    voice_key [VOICES],
    input  wire synth_pkg::bend_t   pitch_val,
    output synth_pkg::phase_t       osc_inc,
    slot_if.source                  slot_d1     // slot fields aligned with osc_inc
);

    localparam int SLOTS = VOICES * V_OSC;

    logic signed [7:0]  detune [SLOTS];
    int                 wr_idx;
    int                 slot_idx;
    logic signed [14:0] bend_ofs;
    synth_pkg::phase_t  inc_nxt;

    always_comb begin
        wr_idx   = int'(cfg.adr) - int'(synth_pkg::ADR_DETUNE);
        slot_idx = int'(slot.voice) * V_OSC + int'(slot.osc);
        bend_ofs = $signed({1'b0, pitch_val}) - $signed({1'b0, synth_pkg::BEND_CENTRE});
        inc_nxt  = synth_pkg::phase_t'({voice_key[slot.voice], 4'b0000})  // key * 16
                 + synth_pkg::phase_t'(detune[slot_idx])
                 + synth_pkg::phase_t'(bend_ofs >>> 6);                     // wraps
    end

    always_ff @(posedge audio_clk) begin
        if (reset) begin
            for (int i = 0; i < SLOTS; i++) begin
                detune[i] <= '0;
            end
        end else if (cfg.write && cfg.osc_sel && wr_idx >= 0 && wr_idx < SLOTS) begin
            detune[wr_idx] <= $signed(cfg.data);
        end
    end

    always_ff @(posedge audio_clk) begin
        if (reset) begin
            slot_d1.slot_valid  <= 1'b0;
            slot_d1.frame_start <= 1'b0;
            slot_d1.frame_end   <= 1'b0;
        end else begin
            slot_d1.slot_valid  <= slot.slot_valid;
            slot_d1.frame_start <= slot.frame_start;
            slot_d1.frame_end   <= slot.frame_end;
        end
    end

    always_ff @(posedge audio_clk) begin
        osc_inc       <= inc_nxt;
        slot_d1.voice <= slot.voice;
        slot_d1.osc   <= slot.osc;
    end

endmodule

`default_nettype wire

/* synth_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module synth_clk_gen #(
    parameter int VOICES = synth_pkg::VOICES,
    parameter int V_OSC  = synth_pkg::V_OSC
) (
    input  wire     audio_clk,
    input  wire     reset,
    input  wire     trig,
    slot_if.source  slot,
    output logic    xxxx_zero
);

    localparam int SLOTS = VOICES * V_OSC;
    localparam int CW    = $clog2(SLOTS);

    typedef enum logic {st_idle, st_run} state_e;

    state_e        state;
    logic [CW-1:0] cnt;                          // slot number in the sweep
    logic          last;

    always_ff @(posedge audio_clk) begin
        if (reset) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: if (trig) begin         // trig during a sweep is dropped
                    state <= st_run;
                    cnt   <= '0;
                end
                st_run: begin
                    if (last) state <= st_idle;
                    else      cnt   <= cnt + 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_comb begin
        last             = (cnt == CW'(SLOTS - 1));
        slot.slot_valid  = (state == st_run);
        slot.voice       = synth_pkg::voice_t'(cnt / V_OSC);
        slot.osc         = synth_pkg::osc_t'(cnt % V_OSC);
        slot.frame_start = (state == st_run) && (cnt == '0);
        slot.frame_end   = (state == st_run) && last;
        xxxx_zero        = (state == st_run) && (cnt == '0);
    end

endmodule

`default_nettype wire

/* synth_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module synth_engine #(
    parameter int VOICES = synth_pkg::VOICES,
    parameter int V_OSC  = synth_pkg::V_OSC
) (
    input  wire                         audio_clk,
    input  wire                         reset,
    input  wire                         trig,
    // note events
    input  wire [VOICES-1:0]            keys_on,
    input  wire                         note_on,
    input  wire synth_pkg::voice_t      cur_key_adr,
    input  wire synth_pkg::key_t        cur_key_val,
    input  wire synth_pkg::vel_t        cur_vel_on,
    // patch register writes
    input  wire                         write,
    input  wire synth_pkg::reg_adr_t    adr,
    input  wire synth_pkg::reg_data_t   data,
    input  wire                         env_sel,
    input  wire                         osc_sel,
    input  wire                         com_sel,
    input  wire synth_pkg::bend_t       pitch_val,
    output synth_pkg::sample_t          lsound_out,
    output synth_pkg::sample_t          rsound_out,
    output logic                        sample_valid,
    output logic                        xxxx_zero,
    output logic [VOICES-1:0]           voice_free
);

    synth_pkg::key_t    voice_key [VOICES];
    synth_pkg::vel_t    voice_vel [VOICES];
    logic [VOICES-1:0]  reg_keys_on;
    synth_pkg::phase_t  osc_inc;
    synth_pkg::sample_t sample;
    logic               pan;
    synth_pkg::level_t  level_mul;

    slot_if slot ();
    slot_if slot_d1 ();                         // pitch stage
    slot_if slot_d2 ();                         // osc stage

    cfg_if cfg (
        .write   (write),
        .adr     (adr),
        .data    (data),
        .env_sel (env_sel),
        .osc_sel (osc_sel),
        .com_sel (com_sel)
    );

    synth_clk_gen #(.VOICES(VOICES), .V_OSC(V_OSC)) synth_clk_gen_inst (
        .audio_clk (audio_clk),
        .reset     (reset),
        .trig      (trig),
        .slot      (slot.source),
        .xxxx_zero (xxxx_zero)
    );

    note_key_vel_sync #(.VOICES(VOICES)) key_sync_inst (
        .audio_clk   (audio_clk),
        .reset       (reset),
        .frame_start (slot.frame_start),
        .note_on     (note_on),
        .cur_key_adr (cur_key_adr),
        .cur_key_val (cur_key_val),
        .cur_vel_on  (cur_vel_on),
        .keys_on     (keys_on),
        .voice_key   (voice_key),
        .voice_vel   (voice_vel),
        .reg_keys_on (reg_keys_on)
    );

    pitch_control #(.VOICES(VOICES), .V_OSC(V_OSC)) pitch_control_inst (
        .audio_clk (audio_clk),
        .reset     (reset),
        .slot      (slot.monitor),
        .cfg       (cfg.osc_cfg),
        .voice_key (voice_key),
        .pitch_val (pitch_val),
        .osc_inc   (osc_inc),
        .slot_d1   (slot_d1.source)
    );

    osc #(.VOICES(VOICES), .V_OSC(V_OSC)) osc_inst (
        .audio_clk (audio_clk),
        .reset     (reset),
        .slot_d1   (slot_d1.monitor),
        .cfg       (cfg.osc_cfg),
        .osc_inc   (osc_inc),
        .sample    (sample),
        .pan       (pan),
        .slot_d2   (slot_d2.source)
    );

    env_gen_indexed #(.VOICES(VOICES)) env_gen_indexed_inst (
        .audio_clk   (audio_clk),
        .reset       (reset),
        .slot        (slot.monitor),
        .cfg         (cfg.env_cfg),
        .reg_keys_on (reg_keys_on),
        .level_mul   (level_mul),
        .voice_free  (voice_free)
    );

    mixer #(.VOICES(VOICES)) mixer_inst (
        .audio_clk    (audio_clk),
        .reset        (reset),
        .slot_d2      (slot_d2.monitor),
        .sample       (sample),
        .pan          (pan),
        .level_mul    (level_mul),
        .voice_vel    (voice_vel),
        .lsound_out   (lsound_out),
        .rsound_out   (rsound_out),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

/* synth_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one slot of the sweep, copied down the pipeline
interface slot_if;
    logic              slot_valid;
    synth_pkg::voice_t voice;
    synth_pkg::osc_t   osc;
    logic              frame_start;             // slot 0
    logic              frame_end;               // last slot

    modport source  (output slot_valid, voice, osc, frame_start, frame_end);
    modport monitor (input  slot_valid, voice, osc, frame_start, frame_end);
endinterface

// write-only patch register bus
interface cfg_if (
    input wire                       write,
    input wire synth_pkg::reg_adr_t  adr,
    input wire synth_pkg::reg_data_t data,
    input wire                       env_sel,
    input wire                       osc_sel,
    input wire                       com_sel    // no common registers yet
);
    modport osc_cfg (input write, adr, data, osc_sel);
    modport env_cfg (input write, adr, data, env_sel);
endinterface

`default_nettype wire

/* synth_pkg.sv */
`default_nettype none

package synth_pkg;

    localparam int VOICES = 8;
    localparam int V_OSC  = 4;                      // oscillators per voice

    // index types follow the default sizes
    typedef logic [$clog2(VOICES)-1:0] voice_t;
    typedef logic [$clog2(V_OSC)-1:0]  osc_t;

    typedef logic [7:0]         key_t;
    typedef logic [7:0]         vel_t;
    typedef logic [7:0]         level_t;
    typedef logic [15:0]        phase_t;
    typedef logic signed [15:0] sample_t;
    typedef logic signed [23:0] acc_t;              // frame sum, headroom for all slots
    typedef logic [13:0]        bend_t;
    typedef logic [6:0]         reg_adr_t;
    typedef logic [7:0]         reg_data_t;

    localparam bend_t BEND_CENTRE = 14'd8192;

    // osc_sel register map, base + slot
    localparam reg_adr_t ADR_DETUNE = 7'd0;
    localparam reg_adr_t ADR_WAVE   = 7'd32;
    localparam reg_adr_t ADR_PAN    = 7'd64;        // 0 left, 1 right

    // env_sel register map
    localparam reg_adr_t ADR_ATTACK  = 7'd0;
    localparam reg_adr_t ADR_RELEASE = 7'd1;

    typedef enum logic [1:0] {
        wave_saw    = 2'd0,
        wave_square = 2'd1,
        wave_tri    = 2'd2
    } wave_e;

endpackage

`default_nettype wire

/* tb_synth_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_synth_engine;

    localparam int VOICES        = synth_pkg::VOICES;
    localparam int V_OSC         = synth_pkg::V_OSC;
    localparam int SLOTS         = VOICES * V_OSC;
    localparam int LATENCY       = SLOTS + 3;       // posedges from trig drive where the first samples trig
    localparam int FRAME_TIMEOUT = 4 * SLOTS;

    logic                   audio_clk = 1'b0;
    logic                   reset;
    logic                   trig;
    logic [VOICES-1:0]      keys_on;
    logic                   note_on;
    synth_pkg::voice_t      cur_key_adr;
    synth_pkg::key_t        cur_key_val;
    synth_pkg::vel_t        cur_vel_on;
    logic                   write;
    synth_pkg::reg_adr_t    adr;
    synth_pkg::reg_data_t   data;
    logic                   env_sel;
    logic                   osc_sel;
    logic                   com_sel;
    synth_pkg::bend_t       pitch_val;
    synth_pkg::sample_t     lsound_out;
    synth_pkg::sample_t     rsound_out;
    logic                   sample_valid;
    logic                   xxxx_zero;
    logic [VOICES-1:0]      voice_free;

    // reference model state
    int                m_phase  [SLOTS];
    int                m_detune [SLOTS];
    int                m_wave   [SLOTS];
    logic              m_pan    [SLOTS];
    int                m_level  [VOICES];
    int                m_key    [VOICES];
    int                m_vel    [VOICES];
    logic [VOICES-1:0] m_keys;
    int                m_attack;
    int                m_release;
    int                sat_frames;                  // frames where the model clipped
    logic [31:0]       rng_state = 32'h36c3_f76c;

    always #10 audio_clk = ~audio_clk;

    synth_engine #(.VOICES(VOICES), .V_OSC(V_OSC)) dut0 (
        .audio_clk    (audio_clk),
        .reset        (reset),
        .trig         (trig),
        .keys_on      (keys_on),
        .note_on      (note_on),
        .cur_key_adr  (cur_key_adr),
        .cur_key_val  (cur_key_val),
        .cur_vel_on   (cur_vel_on),
        .write        (write),
        .adr          (adr),
        .data         (data),
        .env_sel      (env_sel),
        .osc_sel      (osc_sel),
        .com_sel      (com_sel),
        .pitch_val    (pitch_val),
        .lsound_out   (lsound_out),
        .rsound_out   (rsound_out),
        .sample_valid (sample_valid),
        .xxxx_zero    (xxxx_zero),
        .voice_free   (voice_free)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic stop_failed(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_sample(input string name, input synth_pkg::sample_t got,
                                input synth_pkg::sample_t want);
        if (got !== want)
            stop_failed($sformatf("ERROR t=%0t %s got %0d expected %0d", $time, name, got, want));
    endtask

    task automatic check_free(input logic [VOICES-1:0] got, input logic [VOICES-1:0] want);
        if (got !== want)
            stop_failed($sformatf("ERROR t=%0t voice_free got %b expected %b", $time, got, want));
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want)
            stop_failed($sformatf("ERROR t=%0t %s got %b expected %b", $time, name, got, want));
    endtask

    // square for code 1, triangle for code 2, saw for the others
    function automatic int wave_value(input int code, input int ph);
        int d;
        case (code)
            1: return (ph >= 32768) ? -16384 : 16383;
            2: begin
                d = (ph * 2) % 65536;
                if (ph >= 32768) d = 65535 - d;
                return d - 32768;
            end
            default: return (ph >= 32768) ? ph - 65536 : ph;
        endcase
    endfunction

    function automatic synth_pkg::sample_t clip16(input int a);
        if (a > 32767) return 16'sd32767;
        if (a < -32768) return -16'sd32768;
        return synth_pkg::sample_t'(a);
    endfunction

    function automatic logic [VOICES-1:0] expected_free();
        logic [VOICES-1:0] f;
        for (int v = 0; v < VOICES; v++) f[v] = (m_level[v] == 0) && !m_keys[v];
        return f;
    endfunction

    // one frame of the model from the note inputs held for this frame
    task automatic predict_frame(output synth_pkg::sample_t exp_l,
                                 output synth_pkg::sample_t exp_r);
        int     bend_ofs;
        int     inc;
        int     v;
        int     acc_l;
        int     acc_r;
        longint prod;
        if (note_on) begin
            m_key[cur_key_adr] = cur_key_val;
            m_vel[cur_key_adr] = cur_vel_on;
        end
        m_keys = keys_on;
        for (int i = 0; i < VOICES; i++) begin
            if (m_keys[i]) m_level[i] = (m_level[i] + m_attack > 255) ? 255 : m_level[i] + m_attack;
            else           m_level[i] = (m_level[i] > m_release) ? m_level[i] - m_release : 0;
        end
        bend_ofs = (int'(pitch_val) - 8192) >>> 6;  // floor division by 64
        acc_l    = 0;
        acc_r    = 0;
        for (int s = 0; s < SLOTS; s++) begin
            v          = s / V_OSC;
            inc        = m_key[v] * 16 + m_detune[s] + bend_ofs;
            m_phase[s] = (m_phase[s] + inc) & 'hffff;
            prod       = longint'(wave_value(m_wave[s], m_phase[s])) * m_level[v] * m_vel[v];
            prod       = prod >>> 16;
            if (m_pan[s]) acc_r += int'(prod);
            else          acc_l += int'(prod);
        end
        if (acc_l > 32767 || acc_l < -32768 || acc_r > 32767 || acc_r < -32768) sat_frames++;
        exp_l = clip16(acc_l);
        exp_r = clip16(acc_r);
    endtask

    // one register bus cycle that also updates the model copy
    task automatic reg_write(input logic es, input logic os, input logic cs,
                             input synth_pkg::reg_adr_t a, input synth_pkg::reg_data_t d);
        write   = 1'b1;
        env_sel = es;
        osc_sel = os;
        com_sel = cs;
        adr     = a;
        data    = d;
        @(negedge audio_clk);
        write   = 1'b0;
        env_sel = 1'b0;
        osc_sel = 1'b0;
        com_sel = 1'b0;
        if (os) begin
            if (a < 32)      m_detune[a] = int'($signed(d));
            else if (a < 64) m_wave[a - 32] = int'(d[1:0]);
            else if (a < 96) m_pan[a - 64] = d[0];
        end
        if (es && a == 0) m_attack = int'(d);
        if (es && a == 1) m_release = int'(d);
    endtask

    task automatic randomize_frame_inputs();
        logic [31:0] r;
        int          nw;
        nw = int'(next_rand() % 4);
        repeat (nw) begin
            r = next_rand();
            case (r[2:0])
                3'd0:    reg_write(1'b1, 1'b0, r[3], synth_pkg::reg_adr_t'(r[8]), r[23:16]);
                3'd1:    reg_write(1'b0, 1'b0, 1'b1, r[14:8], r[23:16]);     // common only
                default: reg_write(1'b0, 1'b1, r[3], synth_pkg::reg_adr_t'(r[14:8] % 96), r[23:16]);
            endcase
        end
        r = next_rand();
        note_on     = r[0] | r[1];
        cur_key_adr = synth_pkg::voice_t'(r[4:2]);
        cur_key_val = r[15:8];
        cur_vel_on  = r[23:16];
        if (r[25:24] == 2'd0) begin                 // occasional key change
            r = next_rand();
            keys_on = r[VOICES-1:0];
        end
        r = next_rand();
        pitch_val = r[13:0];
    endtask

    task automatic run_frame(input logic mid_trig);
        synth_pkg::sample_t exp_l;
        synth_pkg::sample_t exp_r;
        int                 n;
        predict_frame(exp_l, exp_r);
        n     = 0;
        trig  = 1'b1;
        do begin
            @(negedge audio_clk);
            n++;
            trig = mid_trig && (n == 12);           // stray pulse inside the sweep
            check_bit("xxxx_zero", xxxx_zero, n == 1);  // slot 0 follows the trig edge
            if (n > FRAME_TIMEOUT) stop_failed("timeout while waiting for sample_valid");
        end while (!sample_valid);
        if (n != LATENCY)
            stop_failed($sformatf("ERROR t=%0t sample_valid latency got %0d expected %0d",
                                  $time, n, LATENCY));
        check_sample("lsound_out", lsound_out, exp_l);
        check_sample("rsound_out", rsound_out, exp_r);
        repeat (mid_trig ? SLOTS + 6 : 1) begin
            @(negedge audio_clk);
            check_bit("sample_valid", sample_valid, 1'b0);
            check_bit("xxxx_zero", xxxx_zero, 1'b0);
        end
        check_free(voice_free, expected_free());
    endtask

    initial begin
        int limit;
        reset       = 1'b1;
        trig        = 1'b0;
        keys_on     = '0;
        note_on     = 1'b0;
        cur_key_adr = '0;
        cur_key_val = '0;
        cur_vel_on  = '0;
        write       = 1'b0;
        adr         = '0;
        data        = '0;
        env_sel     = 1'b0;
        osc_sel     = 1'b0;
        com_sel     = 1'b0;
        pitch_val   = 14'd8192;
        for (int s = 0; s < SLOTS; s++) begin
            m_phase[s]  = 0;
            m_detune[s] = 0;
            m_wave[s]   = 0;
            m_pan[s]    = 1'b0;
        end
        for (int v = 0; v < VOICES; v++) begin
            m_level[v] = 0;
            m_key[v]   = 0;
            m_vel[v]   = 0;
        end
        m_keys     = '0;
        m_attack   = 0;
        m_release  = 0;
        sat_frames = 0;

        repeat (10) @(negedge audio_clk);
        reset = 1'b0;
        @(negedge audio_clk);
        check_sample("lsound_out", lsound_out, 16'sd0);
        check_sample("rsound_out", rsound_out, 16'sd0);
        check_free(voice_free, '1);
        check_bit("sample_valid", sample_valid, 1'b0);
        check_bit("xxxx_zero", xxxx_zero, 1'b0);

        // random patch, notes and bend with a stray trig now and then
        for (int f = 0; f < 200; f++) begin
            randomize_frame_inputs();
            run_frame(f % 40 == 20);
        end

        // build up levels and then release every key
        note_on = 1'b0;
        keys_on = '1;
        reg_write(1'b1, 1'b0, 1'b0, 7'd0, 8'd40);
        repeat (3) run_frame(1'b0);
        keys_on = '0;
        reg_write(1'b1, 1'b0, 1'b0, 7'd1, synth_pkg::reg_data_t'(1 + next_rand() % 15));
        limit = 0;
        do begin
            run_frame(1'b0);
            limit++;
            if (limit > 300) stop_failed("voices never became free after the keys were released");
        end while (expected_free() != '1);

        // full scale with fast attack, full velocity and left-panned square waves
        reg_write(1'b1, 1'b0, 1'b0, 7'd0, 8'd255);
        for (int s = 0; s < SLOTS; s++) begin
            reg_write(1'b0, 1'b1, 1'b0, synth_pkg::reg_adr_t'(64 + s), 8'd0);
            reg_write(1'b0, 1'b1, 1'b0, synth_pkg::reg_adr_t'(32 + s), 8'd1);
        end
        keys_on    = '1;
        sat_frames = 0;
        for (int v = 0; v < VOICES; v++) begin
            note_on     = 1'b1;
            cur_key_adr = synth_pkg::voice_t'(v);
            cur_key_val = synth_pkg::key_t'(next_rand());
            cur_vel_on  = 8'd255;
            run_frame(1'b0);
        end
        note_on = 1'b0;
        repeat (8) run_frame(1'b0);
        if (sat_frames == 0) stop_failed("full-scale frames never drove the sums into clipping");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
